// ==== files.f ====
+incdir+.
subcarr_pkg.sv
dac_spi_if.sv
host_regs.sv
reset_stretch.sv
dac_channel.sv
symbol_route.sv
dac_serial.sv
subcarr_top.sv
tb_subcarr.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log says so
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_subcarr -Mdir obj_dir \
  && ./obj_dir/Vtb_subcarr > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }

// ==== tb_subcarr.sv ====
`include "subcarr_cfg.svh"

module tb_subcarr;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TEST_CYCLES = 64 * 8 + 400 + 3 * 150 + 200;
  localparam logic [7:0] DAC_BYTE = 8'ha5; // returned by the dac model on reads

  logic ck933, rs, wr_i, rd_i, sdio_i;
  logic [`ADDR_W-1:0] addr_i;
  logic [`DATA_W-1:0] wdata_i, rdata_o;
  logic [`DAC_W-1:0] ext_dac0_i, ext_dac1_i, ext_dac2_i;
  logic [`DAC_W-1:0] dac0_d_o, dac1_d_o, dac2_d_o;
  logic [`DEMOD_W-1:0] demod_dac0_i, demod_dac1_i, demod_dac2_i;
  logic ext_i_i, ext_q_i, ext_sym_en_i, ext_sym2x_en_i;
  logic demod_i_i, demod_q_i, demod_sym_en_i, demod_sym2x_en_i;
  logic [3:0] demod_mode_i;
  logic dac_rst_o, dac_sclk_o, sdio_o, sdio_oe_o, reboot_o;
  logic [2:0] dac_ncs_o;
  logic [`BOOT_W-1:0] boot_addr_o;
  logic dec_i_o, dec_q_o, dec_sym_en_o, dec_sym2x_en_o;

  subcarr_top UUT (.*);

  // ****************************************
  // reporting
  // ****************************************
  task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic abort_run(string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("test failed");
    $fatal(1);
  endtask

  function automatic logic [13:0] dac_expect(logic [1:0] src, logic [13:0] e, logic [17:0] d);
    logic [13:0] v;
    case (src)
      2'd0:    v = e;
      2'd1:    v = d[17:4]; // top 14 of 18
      default: v = 14'd0;
    endcase
    return {~v[13], v[12:0]};
  endfunction

  // active low select pattern of one dac
  function automatic logic [2:0] ncs_for_chan(logic [1:0] chan);
    case (chan)
      2'd0:    return 3'b110;
      2'd1:    return 3'b101;
      2'd2:    return 3'b011;
      default: return 3'b111;
    endcase
  endfunction

  initial begin
    ck933 = 1'b0;
    forever #4 ck933 = ~ck933;
  end

  // random samples and symbols 1 ns after the edge
  always @(posedge ck933) begin
    #1;
    ext_dac0_i   = 14'($urandom);
    ext_dac1_i   = 14'($urandom);
    ext_dac2_i   = 14'($urandom);
    demod_dac0_i = 18'($urandom);
    demod_dac1_i = 18'($urandom);
    demod_dac2_i = 18'($urandom);
    {ext_sym2x_en_i, ext_sym_en_i, ext_q_i, ext_i_i} = 4'($urandom);
    {demod_sym2x_en_i, demod_sym_en_i, demod_q_i, demod_i_i} = 4'($urandom);
    demod_mode_i = 4'($urandom);
  end

  // ****************************************
  // reference models checked at negedge
  // ****************************************
  logic [13:0] ext_h [3][4];
  logic [17:0] dem_h [3][4];
  logic [5:0]  sel_h [4];
  logic [3:0]  sx_h [3], sd_h [3], mode_h [3];
  logic        dsel_h [3];
  logic [5:0]  m_sel = '0;
  logic        m_dsel = 1'b0;
  logic [23:0] m_boot = '0;
  logic [15:0] pend_rdata;
  logic        pend_rd = 1'b0, pend_check = 1'b0, prev_boot_wr = 1'b0;
  logic        exp_q;
  int          ncyc = 0, quiet = 0, rst_left = 0;

  always @(negedge ck933) begin
    ncyc++;
    for (int k = 3; k > 0; k--) begin
      sel_h[k] = sel_h[k-1];
      for (int c = 0; c < 3; c++) begin
        ext_h[c][k] = ext_h[c][k-1];
        dem_h[c][k] = dem_h[c][k-1];
      end
    end
    sel_h[0] = m_sel;
    ext_h[0][0] = ext_dac0_i;
    ext_h[1][0] = ext_dac1_i;
    ext_h[2][0] = ext_dac2_i;
    dem_h[0][0] = demod_dac0_i;
    dem_h[1][0] = demod_dac1_i;
    dem_h[2][0] = demod_dac2_i;
    for (int k = 2; k > 0; k--) begin
      sx_h[k] = sx_h[k-1];
      sd_h[k] = sd_h[k-1];
      mode_h[k] = mode_h[k-1];
      dsel_h[k] = dsel_h[k-1];
    end
    sx_h[0]   = {ext_sym2x_en_i, ext_sym_en_i, ext_q_i, ext_i_i};
    sd_h[0]   = {demod_sym2x_en_i, demod_sym_en_i, demod_q_i, demod_i_i};
    mode_h[0] = demod_mode_i;
    dsel_h[0] = m_dsel;

    if (ncyc >= 4) begin
      assert (dac0_d_o === dac_expect(sel_h[3][1:0], ext_h[0][3], dem_h[0][3]))
        else mismatch("dac0_d_o", 32'(dac0_d_o),
                      32'(dac_expect(sel_h[3][1:0], ext_h[0][3], dem_h[0][3])));
      assert (dac1_d_o === dac_expect(sel_h[3][3:2], ext_h[1][3], dem_h[1][3]))
        else mismatch("dac1_d_o", 32'(dac1_d_o),
                      32'(dac_expect(sel_h[3][3:2], ext_h[1][3], dem_h[1][3])));
      assert (dac2_d_o === dac_expect(sel_h[3][5:4], ext_h[2][3], dem_h[2][3]))
        else mismatch("dac2_d_o", 32'(dac2_d_o),
                      32'(dac_expect(sel_h[3][5:4], ext_h[2][3], dem_h[2][3])));
    end

    quiet = dac_rst_o ? 0 : quiet + 1;
    if (quiet >= 3) begin
      exp_q = (dsel_h[2] && mode_h[2] != 4'd6 && mode_h[2] != 4'd7) ?
              sd_h[2][1] : sx_h[2][1];
      assert (dec_i_o === (dsel_h[2] ? sd_h[2][0] : sx_h[2][0]))
        else mismatch("dec_i_o", 32'(dec_i_o), 32'(dsel_h[2] ? sd_h[2][0] : sx_h[2][0]));
      assert (dec_q_o === exp_q) else mismatch("dec_q_o", 32'(dec_q_o), 32'(exp_q));
      assert (dec_sym_en_o === (dsel_h[2] ? sd_h[2][2] : sx_h[2][2]))
        else mismatch("dec_sym_en_o", 32'(dec_sym_en_o),
                      32'(dsel_h[2] ? sd_h[2][2] : sx_h[2][2]));
      assert ({dec_sym2x_en_o} === (dsel_h[2] ? sd_h[2][3] : sx_h[2][3]))
        else mismatch("dec_sym2x_en_o", 32'(dec_sym2x_en_o),
                      32'(dsel_h[2] ? sd_h[2][3] : sx_h[2][3]));
    end

    // stretched reset lasts 5 cycles after rs or a soft reset write
    if (rs) rst_left = `RESET_STRETCH;
    assert (dac_rst_o === (rs || rst_left > 0))
      else mismatch("dac_rst_o", 32'(dac_rst_o), 32'(rs || rst_left > 0));
    if (!rs && rst_left > 0) rst_left--;

    assert (reboot_o === prev_boot_wr)
      else mismatch("reboot_o", 32'(reboot_o), 32'(prev_boot_wr));
    if (pend_rd && pend_check) begin
      assert (rdata_o === pend_rdata) else mismatch("rdata_o", 32'(rdata_o), 32'(pend_rdata));
    end

    // capture this cycle's bus access before the register model update
    pend_rd = rd_i;
    pend_check = (addr_i != `REG_SPI_STAT);
    case (addr_i)
      `REG_VERSION:    pend_rdata = `VER_NUMBER;
      `REG_DAC_IN_SEL: pend_rdata = {10'd0, m_sel};
      `REG_DEC_IN_SEL: pend_rdata = {15'd0, m_dsel};
      `REG_BOOT_LO:    pend_rdata = {8'd0, m_boot[7:0]};
      `REG_BOOT_MID:   pend_rdata = {8'd0, m_boot[15:8]};
      `REG_BOOT_HI:    pend_rdata = {8'd0, m_boot[23:16]};
      default:         pend_rdata = 16'd0;
    endcase
    prev_boot_wr = wr_i && !rs && addr_i == `REG_BOOT_HI;
    if (wr_i && !rs) begin
      case (addr_i)
        `REG_DAC_IN_SEL: m_sel = wdata_i[5:0];
        `REG_DEC_IN_SEL: m_dsel = wdata_i[0];
        `REG_BOOT_LO:    m_boot[7:0] = wdata_i[7:0];
        `REG_BOOT_MID:   m_boot[15:8] = wdata_i[7:0];
        `REG_BOOT_HI:    m_boot[23:16] = wdata_i[7:0];
        `REG_MISC_RESET: rst_left = `RESET_STRETCH;
        default: ;
      endcase
    end
  end

  a_reboot_pulse: assert property (@(posedge ck933) disable iff (rs) reboot_o |=> !reboot_o)
    else abort_run("reboot_o stayed high for two cycles");

  // ****************************************
  // dac serial port model
  // ****************************************
  logic [15:0] exp_frame, frame_sr;
  logic [1:0]  exp_chan;
  logic        exp_rd = 1'b0;
  logic        exp_oe;
  logic [2:0]  ncs_prev = 3'b111;
  int          rise_cnt = 0, frames_seen = 0;

  always @(posedge dac_sclk_o) begin
    frame_sr = {frame_sr[14:0], sdio_o};
    rise_cnt++;
    exp_oe = !(exp_rd && rise_cnt > 8); // dac owns the line for the read byte
    assert (sdio_oe_o === exp_oe) else mismatch("sdio_oe_o", 32'(sdio_oe_o), 32'(exp_oe));
  end

  always @(negedge dac_sclk_o) begin
    #1;
    sdio_i = (exp_rd && rise_cnt >= 8 && rise_cnt < 16) ? DAC_BYTE[15 - rise_cnt] : 1'b0;
  end

  always @(negedge ck933) begin
    if (dac_ncs_o != 3'b111) begin
      assert (dac_ncs_o === ncs_for_chan(exp_chan))
        else mismatch("dac_ncs_o", 32'(dac_ncs_o), 32'(ncs_for_chan(exp_chan)));
    end
    if (ncs_prev != 3'b111 && dac_ncs_o == 3'b111) begin
      assert (rise_cnt == `SPI_FRAME) else mismatch("sclk rises", rise_cnt, `SPI_FRAME);
      if (exp_rd) begin
        assert (frame_sr[15:8] === exp_frame[15:8])
          else mismatch("sdio_o frame", 32'(frame_sr[15:8]), 32'(exp_frame[15:8]));
      end else begin
        assert (frame_sr === exp_frame)
          else mismatch("sdio_o frame", 32'(frame_sr), 32'(exp_frame));
      end
      frames_seen++;
      rise_cnt = 0;
    end
    ncs_prev = dac_ncs_o;
  end

  // ****************************************
  // bus tasks and stimulus
  // ****************************************
  task automatic bus_write(logic [11:0] addr, logic [15:0] data);
    @(posedge ck933);
    #1;
    wr_i = 1'b1;
    addr_i = addr;
    wdata_i = data;
    @(posedge ck933);
    #1;
    wr_i = 1'b0;
  endtask

  task automatic bus_read(logic [11:0] addr, output logic [15:0] data);
    @(posedge ck933);
    #1;
    rd_i = 1'b1;
    addr_i = addr;
    @(posedge ck933);
    #1;
    rd_i = 1'b0;
    data = rdata_o;
  endtask

  task automatic spi_wait_idle(output logic [15:0] stat);
    int n;
    n = 0;
    repeat (3) @(posedge ck933);
    bus_read(`REG_SPI_STAT, stat);
    while (stat[8]) begin
      n++;
      if (n > 100) abort_run("serial port stayed busy");
      bus_read(`REG_SPI_STAT, stat);
    end
  endtask

  task automatic spi_command(logic rd, logic [1:0] chan, logic [4:0] ra, logic [7:0] d);
    exp_rd = rd;
    exp_chan = chan;
    exp_frame = {rd, 2'b00, ra, d};
    bus_write(`REG_SPI_CMD, {rd, chan, ra, d});
  endtask

  initial begin
    logic [15:0] v;
    int n;
    void'($urandom(32'h48c4));
    rs = 1'b1;
    wr_i = 1'b0;
    rd_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    sdio_i = 1'b0;
    ext_dac0_i = '0;
    ext_dac1_i = '0;
    ext_dac2_i = '0;
    demod_dac0_i = '0;
    demod_dac1_i = '0;
    demod_dac2_i = '0;
    {ext_i_i, ext_q_i, ext_sym_en_i, ext_sym2x_en_i} = 4'd0;
    {demod_i_i, demod_q_i, demod_sym_en_i, demod_sym2x_en_i} = 4'd0;
    demod_mode_i = '0;
    repeat (5) @(posedge ck933);
    #1 rs = 1'b0;
    repeat (10) @(posedge ck933);

    bus_read(`REG_VERSION, v);
    bus_write(`REG_DEC_IN_SEL, 16'h0001);
    bus_read(`REG_DEC_IN_SEL, v);
    bus_read(12'h3f0, v); // unmapped
    repeat (150) @(posedge ck933);
    bus_write(`REG_DEC_IN_SEL, 16'h0000);
    repeat (150) @(posedge ck933);

    for (int s = 0; s < 64; s++) begin
      bus_write(`REG_DAC_IN_SEL, 16'(s));
      bus_read(`REG_DAC_IN_SEL, v);
      repeat (4) @(posedge ck933);
    end

    bus_write(`REG_BOOT_LO, 16'h0034);
    bus_write(`REG_BOOT_MID, 16'h0012);
    bus_write(`REG_BOOT_HI, 16'h00ab);
    assert (boot_addr_o === 24'hab1234)
      else mismatch("boot_addr_o", 32'(boot_addr_o), 32'h00ab1234);
    bus_read(`REG_BOOT_HI, v);

    bus_write(`REG_MISC_RESET, 16'h0001);
    repeat (12) @(posedge ck933);

    n = frames_seen;
    spi_command(1'b0, 2'd1, 5'h0b, 8'h3c);
    repeat (5) @(posedge ck933);
    bus_write(`REG_SPI_CMD, 16'h4f77); // dropped while the engine is busy
    spi_wait_idle(v);
    repeat (20) @(posedge ck933);
    assert (frames_seen == n + 1) else mismatch("frame count", frames_seen, n + 1);

    spi_command(1'b1, 2'd2, 5'h15, 8'h00);
    spi_wait_idle(v);
    assert (v[7:0] === DAC_BYTE) else mismatch("spi read byte", 32'(v[7:0]), 32'(DAC_BYTE));
    repeat (10) @(posedge ck933);
    assert (frames_seen == n + 2) else mismatch("frame count", frames_seen, n + 2);

    $display("test passed");
    $finish;
  end

  initial begin
    #((TEST_CYCLES + 500) * 8);
    abort_run("watchdog timeout, run did not finish");
  end

endmodule

// ==== subcarr_top.sv ====
`include "subcarr_cfg.svh"

module subcarr_top (
  input  logic                ck933,
  input  logic                rs,
  // processor bus
  input  logic                wr_i,
  input  logic                rd_i,
  input  logic [`ADDR_W-1:0]  addr_i,
  input  logic [`DATA_W-1:0]  wdata_i,
  output logic [`DATA_W-1:0]  rdata_o,
  // samples
  input  logic [`DAC_W-1:0]   ext_dac0_i,
  input  logic [`DAC_W-1:0]   ext_dac1_i,
  input  logic [`DAC_W-1:0]   ext_dac2_i,
  input  logic [`DEMOD_W-1:0] demod_dac0_i,
  input  logic [`DEMOD_W-1:0] demod_dac1_i,
  input  logic [`DEMOD_W-1:0] demod_dac2_i,
  // symbols
  input  logic                ext_i_i,
  input  logic                ext_q_i,
  input  logic                ext_sym_en_i,
  input  logic                ext_sym2x_en_i,
  input  logic                demod_i_i,
  input  logic                demod_q_i,
  input  logic                demod_sym_en_i,
  input  logic                demod_sym2x_en_i,
  input  logic [3:0]          demod_mode_i,
  // dacs
  output logic [`DAC_W-1:0]   dac0_d_o,
  output logic [`DAC_W-1:0]   dac1_d_o,
  output logic [`DAC_W-1:0]   dac2_d_o,
  output logic                dac_rst_o,
  output logic [2:0]          dac_ncs_o,
  output logic                dac_sclk_o,
  output logic                sdio_o,
  output logic                sdio_oe_o,
  input  logic                sdio_i,
  // multiboot
  output logic                reboot_o,
  output logic [`BOOT_W-1:0]  boot_addr_o,
  // decoder
  output logic                dec_i_o,
  output logic                dec_q_o,
  output logic                dec_sym_en_o,
  output logic                dec_sym2x_en_o
);

  logic [5:0] dac_sel; // 2 bits per channel, dac0 low
  logic       dec_sel;
  logic       soft_rst;

  dac_spi_if spi_bus ();

  host_regs u_regs (
    .ck933, .rs, .wr_i, .rd_i, .addr_i, .wdata_i, .rdata_o,
    .dac_sel_o(dac_sel), .dec_sel_o(dec_sel), .soft_rst_o(soft_rst),
    .reboot_o, .boot_addr_o, .spi(spi_bus)
  );

  reset_stretch u_rst (.ck933, .rs, .soft_rst_i(soft_rst), .dac_rst_o);

  // ****************************************
  // dac channels
  // ****************************************
  dac_channel u_dac0 (.ck933, .ext_i(ext_dac0_i), .demod_i(demod_dac0_i),
                      .src_i(dac_sel[1:0]), .dac_d_o(dac0_d_o));
  dac_channel u_dac1 (.ck933, .ext_i(ext_dac1_i), .demod_i(demod_dac1_i),
                      .src_i(dac_sel[3:2]), .dac_d_o(dac1_d_o));
  dac_channel u_dac2 (.ck933, .ext_i(ext_dac2_i), .demod_i(demod_dac2_i),
                      .src_i(dac_sel[5:4]), .dac_d_o(dac2_d_o));

  symbol_route u_route (
    .ck933, .dac_rst_i(dac_rst_o), .dec_sel_i(dec_sel), .demod_mode_i,
    .ext_i_i, .ext_q_i, .ext_sym_en_i, .ext_sym2x_en_i,
    .demod_i_i, .demod_q_i, .demod_sym_en_i, .demod_sym2x_en_i,
    .dec_i_o, .dec_q_o, .dec_sym_en_o, .dec_sym2x_en_o
  );

  dac_serial u_spi (
    .ck933, .dac_rst_i(dac_rst_o), .sdio_i,
    .dac_ncs_o, .dac_sclk_o, .sdio_o, .sdio_oe_o, .spi(spi_bus)
  );

endmodule

// ==== dac_serial.sv ====
`include "subcarr_cfg.svh"

module dac_serial (
  input  logic       ck933,
  input  logic       dac_rst_i,
  input  logic       sdio_i,
  output logic [2:0] dac_ncs_o,
  output logic       dac_sclk_o,
  output logic       sdio_o,
  output logic       sdio_oe_o,
  dac_spi_if.engine  spi
);

  localparam int DIV_W = $clog2(`SPI_DIV);
  localparam int BIT_W = $clog2(`SPI_FRAME);
  localparam logic [DIV_W-1:0] DIV_RISE = DIV_W'(`SPI_DIV / 2 - 1);
  localparam logic [DIV_W-1:0] DIV_FALL = DIV_W'(`SPI_DIV - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`SPI_FRAME - 1);
  localparam logic [BIT_W-1:0] BIT_DATA = BIT_W'(`SPI_FRAME - 8); // first data bit

  subcarr_pkg::spi_state_e state;
  logic [DIV_W-1:0]        div_cnt;
  logic [BIT_W-1:0]        bit_cnt;
  logic [`SPI_FRAME-1:0]   tx_sr;
  logic [7:0]              rx_sr;
  logic                    rd_q;

  assign sdio_o = tx_sr[`SPI_FRAME-1]; // msb first

  always_ff @(posedge ck933 or posedge dac_rst_i) begin
    if (dac_rst_i) begin
      state      <= subcarr_pkg::IDLE;
      div_cnt    <= '0;
      bit_cnt    <= '0;
      tx_sr      <= '0;
      rx_sr      <= '0;
      rd_q       <= 1'b0;
      dac_ncs_o  <= '1;
      dac_sclk_o <= 1'b0;
      sdio_oe_o  <= 1'b0;
      spi.busy   <= 1'b0;
      spi.rdata  <= '0;
    end else begin
      case (state)
        subcarr_pkg::IDLE: begin
          if (spi.start && spi.chan != 2'd3) begin
            tx_sr     <= {spi.rd, 2'b00, spi.reg_addr, spi.wdata};
            rd_q      <= spi.rd;
            dac_ncs_o <= ~(3'b001 << spi.chan);
            sdio_oe_o <= 1'b1;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            spi.busy  <= 1'b1;
            state     <= subcarr_pkg::SHIFT;
          end
        end

        // ****************************************
        // one bit per sclk period
        // ****************************************
        subcarr_pkg::SHIFT: begin
          div_cnt <= (div_cnt == DIV_FALL) ? '0 : div_cnt + 1'b1;
          if (div_cnt == DIV_RISE) begin
            dac_sclk_o <= 1'b1;
            if (rd_q && bit_cnt >= BIT_DATA) begin
              rx_sr <= {rx_sr[6:0], sdio_i};
            end
          end
          if (div_cnt == DIV_FALL) begin
            dac_sclk_o <= 1'b0; // data moves on this edge
            if (bit_cnt == BIT_LAST) begin
              dac_ncs_o <= '1;
              sdio_oe_o <= 1'b0;
              tx_sr     <= '0;
              state     <= subcarr_pkg::DONE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              tx_sr   <= {tx_sr[`SPI_FRAME-2:0], 1'b0};
              if (rd_q && bit_cnt == BIT_DATA - 1'b1) begin
                sdio_oe_o <= 1'b0; // hand the line to the dac
              end
            end
          end
        end

        subcarr_pkg::DONE: begin
          spi.busy <= 1'b0;
          if (rd_q) begin
            spi.rdata <= rx_sr;
          end
          state <= subcarr_pkg::IDLE;
        end

        default: state <= subcarr_pkg::IDLE;
      endcase
    end
  end

  a_one_select: assert property (@(posedge ck933) disable iff (dac_rst_i)
    $onehot0(~dac_ncs_o));

  a_oe_selected: assert property (@(posedge ck933) disable iff (dac_rst_i)
    sdio_oe_o |-> !(&dac_ncs_o));

endmodule

// ==== symbol_route.sv ====
module symbol_route (
  input  logic       ck933,
  input  logic       dac_rst_i,
  input  logic       dec_sel_i,
  input  logic [3:0] demod_mode_i,
  input  logic       ext_i_i,
  input  logic       ext_q_i,
  input  logic       ext_sym_en_i,
  input  logic       ext_sym2x_en_i,
  input  logic       demod_i_i,
  input  logic       demod_q_i,
  input  logic       demod_sym_en_i,
  input  logic       demod_sym2x_en_i,
  output logic       dec_i_o,
  output logic       dec_q_o,
  output logic       dec_sym_en_o,
  output logic       dec_sym2x_en_o
);

  logic                     dec_sel_q;
  subcarr_pkg::demod_mode_e mode_q;
  logic [3:0]               ext_r;   // {sym2x_en, sym_en, q, i}
  logic [3:0]               demod_r;
  logic                     q_override;

  always_ff @(posedge ck933 or posedge dac_rst_i) begin
    if (dac_rst_i) begin
      dec_sel_q <= 1'b0;
      mode_q    <= subcarr_pkg::MODE_AM;
      ext_r     <= '0;
      demod_r   <= '0;
    end else begin
      dec_sel_q <= dec_sel_i;
      mode_q    <= subcarr_pkg::demod_mode_e'(demod_mode_i);
      ext_r     <= {ext_sym2x_en_i, ext_sym_en_i, ext_q_i, ext_i_i};
      demod_r   <= {demod_sym2x_en_i, demod_sym_en_i, demod_q_i, demod_i_i};
    end
  end

  // aqpsk modes take q from outside whatever the select
  assign q_override = (mode_q == subcarr_pkg::MODE_AQPSK) ||
                      (mode_q == subcarr_pkg::MODE_AUQPSK);

  always_ff @(posedge ck933 or posedge dac_rst_i) begin
    if (dac_rst_i) begin
      dec_i_o        <= 1'b0;
      dec_q_o        <= 1'b0;
      dec_sym_en_o   <= 1'b0;
      dec_sym2x_en_o <= 1'b0;
    end else begin
      dec_i_o        <= dec_sel_q ? demod_r[0] : ext_r[0];
      dec_q_o        <= (dec_sel_q && !q_override) ? demod_r[1] : ext_r[1];
      dec_sym_en_o   <= dec_sel_q ? demod_r[2] : ext_r[2];
      dec_sym2x_en_o <= dec_sel_q ? demod_r[3] : ext_r[3];
    end
  end

endmodule

// ==== dac_channel.sv ====
`include "subcarr_cfg.svh"

module dac_channel (
  input  logic [0:0]          ck933,
  input  logic [`DAC_W-1:0]   ext_i,
  input  logic [`DEMOD_W-1:0] demod_i,
  input  logic [1:0]          src_i,
  output logic [`DAC_W-1:0]   dac_d_o
);

  logic [`DAC_W-1:0]     ext_q;
  logic [`DEMOD_W-1:0]   demod_q;
  subcarr_pkg::dac_src_e src_q;
  logic [`DAC_W-1:0]     mux_q;

  // input reclock, select travels with the samples
  always_ff @(posedge ck933) begin
    ext_q   <= ext_i;
    demod_q <= demod_i;
    src_q   <= subcarr_pkg::dac_src_e'(src_i);
  end

  always_ff @(posedge ck933) begin
    case (src_q)
      subcarr_pkg::SRC_EXT:   mux_q <= ext_q;
      subcarr_pkg::SRC_DEMOD: mux_q <= demod_q[`DEMOD_W-1 -: `DAC_W];
      default:                mux_q <= '0; // both zero codes
    endcase
  end

  // two's complement to offset binary
  always_ff @(posedge ck933) begin
    dac_d_o <= {~mux_q[`DAC_W-1], mux_q[`DAC_W-2:0]};
  end

endmodule

// ==== reset_stretch.sv ====
`include "subcarr_cfg.svh"

module reset_stretch (
  input  logic ck933,
  input  logic rs,
  input  logic soft_rst_i,
  output logic dac_rst_o
);

  localparam int CNT_W = $clog2(`RESET_STRETCH + 1);

  logic [CNT_W-1:0] cnt;

  // count down from RESET_STRETCH, output held until the last count
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      cnt       <= CNT_W'(`RESET_STRETCH);
      dac_rst_o <= 1'b1;
    end else if (soft_rst_i) begin
      cnt       <= CNT_W'(`RESET_STRETCH); // reload, also restarts a running stretch
      dac_rst_o <= 1'b1;
    end else if (cnt != '0) begin
      cnt       <= cnt - 1'b1;
      dac_rst_o <= (cnt != CNT_W'(1));
    end else begin
      dac_rst_o <= 1'b0;
    end
  end

endmodule

// ==== host_regs.sv ====
`include "subcarr_cfg.svh"

module host_regs (
  input  logic                  ck933,
  input  logic                  rs,
  input  logic                  wr_i,
  input  logic                  rd_i,
  input  logic [`ADDR_W-1:0]    addr_i,
  input  logic [`DATA_W-1:0]    wdata_i,
  output logic [`DATA_W-1:0]    rdata_o,
  output subcarr_pkg::dac_sel_t dac_sel_o,
  output logic                  dec_sel_o,
  output logic                  soft_rst_o,
  output logic                  reboot_o,
  output logic [`BOOT_W-1:0]    boot_addr_o,
  dac_spi_if.host               spi
);

  logic               wr_boot_hi;
  logic               wr_spi_cmd;
  logic [`DATA_W-1:0] rd_mux;

  assign wr_boot_hi = wr_i && (addr_i == `REG_BOOT_HI);
  assign wr_spi_cmd = wr_i && (addr_i == `REG_SPI_CMD);
  assign soft_rst_o = wr_i && (addr_i == `REG_MISC_RESET); // stretcher loads on this edge

  // ****************************************
  // control registers
  // ****************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      dac_sel_o   <= subcarr_pkg::dac_sel_t'(6'd0);
      dec_sel_o   <= 1'b0;
      boot_addr_o <= '0;
      reboot_o    <= 1'b0;
    end else begin
      if (wr_i) begin
        case (addr_i)
          `REG_DAC_IN_SEL: dac_sel_o <= subcarr_pkg::dac_sel_t'(wdata_i[5:0]);
          `REG_DEC_IN_SEL: dec_sel_o <= wdata_i[0];
          `REG_BOOT_LO:    boot_addr_o[7:0]   <= wdata_i[7:0];
          `REG_BOOT_MID:   boot_addr_o[15:8]  <= wdata_i[7:0];
          `REG_BOOT_HI:    boot_addr_o[23:16] <= wdata_i[7:0];
          default: ;
        endcase
      end
      reboot_o <= wr_boot_hi; // one clock after the top byte write
    end
  end

  // serial port command word {rd, chan[1:0], addr[4:0], data[7:0]}
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      spi.start    <= 1'b0;
      spi.rd       <= 1'b0;
      spi.chan     <= 2'd0;
      spi.reg_addr <= 5'd0;
      spi.wdata    <= 8'd0;
    end else begin
      spi.start <= wr_spi_cmd; // dropped by the engine while busy
      if (wr_spi_cmd) begin
        spi.rd       <= wdata_i[15];
        spi.chan     <= wdata_i[14:13];
        spi.reg_addr <= wdata_i[12:8];
        spi.wdata    <= wdata_i[7:0];
      end
    end
  end

  // ****************************************
  // read back
  // ****************************************
  always_comb begin
    case (addr_i)
      `REG_VERSION:    rd_mux = `VER_NUMBER;
      `REG_DAC_IN_SEL: rd_mux = {10'd0, dac_sel_o};
      `REG_DEC_IN_SEL: rd_mux = {15'd0, dec_sel_o};
      `REG_BOOT_LO:    rd_mux = {8'd0, boot_addr_o[7:0]};
      `REG_BOOT_MID:   rd_mux = {8'd0, boot_addr_o[15:8]};
      `REG_BOOT_HI:    rd_mux = {8'd0, boot_addr_o[23:16]};
      `REG_SPI_STAT:   rd_mux = {7'd0, spi.busy, spi.rdata};
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      rdata_o <= '0;
    end else if (rd_i) begin
      rdata_o <= rd_mux; // valid the cycle after rd_i
    end
  end

  a_reboot_single: assert property (@(posedge ck933) disable iff (rs)
    reboot_o |=> !reboot_o);

endmodule

// ==== dac_spi_if.sv ====
interface dac_spi_if;

  logic       start;    // one clock, from a command write
  logic       rd;       // read frame
  logic [1:0] chan;     // dac 0..2
  logic [4:0] reg_addr;
  logic [7:0] wdata;
  logic       busy;
  logic [7:0] rdata;    // last byte read back

  modport host (
    output start, rd, chan, reg_addr, wdata,
    input  busy, rdata
  );

  modport engine (
    input  start, rd, chan, reg_addr, wdata,
    output busy, rdata
  );

endinterface

// ==== subcarr_pkg.sv ====
package subcarr_pkg;

  // source choice for one dac channel
  typedef enum logic [1:0] {
    SRC_EXT      = 2'd0, // pass-through from the first fpga
    SRC_DEMOD    = 2'd1, // local demodulator
    SRC_ZERO     = 2'd2,
    SRC_ZERO_ALT = 2'd3  // also zero
  } dac_src_e;

  // demodulator modes as seen by the decoder router
  typedef enum logic [3:0] {
    MODE_AM     = 4'd0,
    MODE_PM     = 4'd1,
    MODE_FM     = 4'd2,
    MODE_BPSK   = 4'd3,
    MODE_QPSK   = 4'd4,
    MODE_OQPSK  = 4'd5,
    MODE_AQPSK  = 4'd6, // q bit comes from the external source
    MODE_AUQPSK = 4'd7
  } demod_mode_e;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    DONE
  } spi_state_e;

  // per channel source selects, dac0 in the low bits
  typedef struct packed {
    dac_src_e dac2;
    dac_src_e dac1;
    dac_src_e dac0;
  } dac_sel_t;

endpackage

// ==== subcarr_cfg.svh ====
`ifndef SUBCARR_CFG_SVH
`define SUBCARR_CFG_SVH

// processor bus
`define ADDR_W          12
`define DATA_W          16
`define VER_NUMBER      16'h017c

// register map, word addresses
`define REG_VERSION     12'h000
`define REG_DAC_IN_SEL  12'h002
`define REG_DEC_IN_SEL  12'h004
`define REG_BOOT_LO     12'h006
`define REG_BOOT_MID    12'h008
`define REG_BOOT_HI     12'h00a // write here triggers reboot
`define REG_MISC_RESET  12'h00c
`define REG_SPI_CMD     12'h00e
`define REG_SPI_STAT    12'h010

// datapath widths
`define DAC_W           14
`define DEMOD_W         18 // channel takes the top DAC_W bits
`define BOOT_W          24

`define RESET_STRETCH   5  // core reset length in clocks
`define SPI_DIV         4  // sclk = ck933 / SPI_DIV
`define SPI_FRAME       16

`endif
